// File: fpmul_pkg.sv
package fpmul_pkg;

    // ieee single precision field widths
    localparam int EXP_W    = 8;
    localparam int FRAC_W   = 23;
    localparam int MANT_W   = FRAC_W + 1;
    localparam int PROD_W   = 2 * MANT_W;
    localparam int EXP_BIAS = 127;

    // registered reduction levels in the carry-save tree
    localparam int CSA_LEVELS = 7;

    // packed word as seen on the ports
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } fp32_t;

    // unpacked operand, hidden bit included in mant
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [MANT_W-1:0] mant;
    } fp_fields_t;

    // sign and biased exponent of the result before normalization
    typedef struct packed {
        logic             sign;
        logic [EXP_W-1:0] exp;
    } sign_exp_t;

endpackage

// File: partial_products.sv
`timescale 1ns/1ps

module partial_products (
    input  logic                                                clk,
    input  logic                                                arst_n,
    input  logic [fpmul_pkg::MANT_W-1:0]                        mant_a,
    input  logic [fpmul_pkg::MANT_W-1:0]                        mant_b,
    output logic [fpmul_pkg::MANT_W-1:0][fpmul_pkg::PROD_W-1:0] rows
);
    import fpmul_pkg::*;

    logic [MANT_W-1:0][PROD_W-1:0] rows_d;

    // row i is mant_a gated by bit i of mant_b, weighted by 2^i
    always_comb begin
        for (int i = 0; i < MANT_W; i++) begin
            rows_d[i] = {{MANT_W{1'b0}}, mant_a & {MANT_W{mant_b[i]}}} << i;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rows <= '0;
        end else begin
            rows <= rows_d;
        end
    end

endmodule

// File: csa_tree.sv
`timescale 1ns/1ps

module csa_tree (
    input  logic                                                clk,
    input  logic                                                arst_n,
    input  logic [fpmul_pkg::MANT_W-1:0][fpmul_pkg::PROD_W-1:0] rows,
    output logic [fpmul_pkg::PROD_W-1:0]                        sum_row,
    output logic [fpmul_pkg::PROD_W-1:0]                        carry_row
);
    import fpmul_pkg::*;

    // rows left after lvl levels of 3:2 compression
    function automatic int rows_at(input int lvl);
        int n;
        n = MANT_W;
        for (int i = 0; i < lvl; i++) begin
            n = 2 * (n / 3) + n % 3;
        end
        return n;
    endfunction

    // 24 -> 16 -> 11 -> 8 -> 6 -> 4 -> 3 -> 2
    for (genvar l = 0; l < CSA_LEVELS; l++) begin : g_lvl
        localparam int N_IN  = rows_at(l);
        localparam int N_CSA = N_IN / 3;
        localparam int N_OUT = rows_at(l + 1);

        logic [N_IN-1:0][PROD_W-1:0]  din;
        logic [N_OUT-1:0][PROD_W-1:0] nxt;
        logic [N_OUT-1:0][PROD_W-1:0] q;

        if (l == 0) begin : g_src_in
            assign din = rows;
        end else begin : g_src_prev
            assign din = g_lvl[l-1].q;
        end

        always_comb begin
            for (int k = 0; k < N_CSA; k++) begin
                nxt[2*k] = din[3*k] ^ din[3*k+1] ^ din[3*k+2];
                // majority moves up one weight, top carry falls off
                nxt[2*k+1] = ((din[3*k] & din[3*k+1]) |
                              (din[3*k] & din[3*k+2]) |
                              (din[3*k+1] & din[3*k+2])) << 1;
            end
            // leftover rows skip this level
            for (int j = 0; j < N_IN % 3; j++) begin
                nxt[2*N_CSA+j] = din[3*N_CSA+j];
            end
        end

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                q <= '0;
            end else begin
                q <= nxt;
            end
        end
    end

    assign sum_row   = g_lvl[CSA_LEVELS-1].q[0];
    assign carry_row = g_lvl[CSA_LEVELS-1].q[1];

endmodule

// File: prefix_adder.sv
`timescale 1ns/1ps

module prefix_adder #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [WIDTH-1:0] x,
    input  logic [WIDTH-1:0] y,
    input  logic             cin,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);
    localparam int LEVELS = $clog2(WIDTH);
    localparam int POS    = WIDTH + 1;

    // kill 00, propagate 01, generate 11; bit 1 is the carry once resolved
    localparam logic [1:0] PROP = 2'b01;

    function automatic logic [1:0] encode(input logic xb, input logic yb);
        return {xb & yb, xb | yb};
    endfunction

    function automatic logic [1:0] combine(input logic [1:0] cur, input logic [1:0] prev);
        return (cur == PROP) ? prev : cur;
    endfunction

    logic [POS-1:0][1:0] kpg_init;
    logic [POS-1:0][1:0] kpg_last;
    logic [WIDTH-1:0]    carry;

    // position 0 is the carry-in, position i+1 is operand bit i
    always_comb begin
        kpg_init[0] = {cin, cin};
        for (int i = 1; i < POS; i++) begin
            kpg_init[i] = encode(x[i-1], y[i-1]);
        end
    end

    for (genvar l = 0; l < LEVELS; l++) begin : g_level
        localparam int DIST = 1 << l;

        logic [POS-1:0][1:0] src;
        logic [POS-1:0][1:0] nxt;
        logic [WIDTH-1:0]    half_src;
        logic [POS-1:0][1:0] kpg_q;
        logic [WIDTH-1:0]    half_q;

        if (l == 0) begin : g_first
            assign src      = kpg_init;
            assign half_src = x ^ y;
        end else begin : g_rest
            assign src      = g_level[l-1].kpg_q;
            assign half_src = g_level[l-1].half_q;
        end

        for (genvar i = 0; i < POS; i++) begin : g_pos
            if (i < DIST) begin : g_keep
                assign nxt[i] = src[i];
            end else begin : g_merge
                assign nxt[i] = combine(src[i], src[i-DIST]);
            end
        end

        // operand xor rides along so the sum uses matching operands
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                kpg_q  <= '0;
                half_q <= '0;
            end else begin
                kpg_q  <= nxt;
                half_q <= half_src;
            end
        end
    end

    assign kpg_last = g_level[LEVELS-1].kpg_q;

    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            carry[i] = kpg_last[i][1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum  <= '0;
            cout <= 1'b0;
        end else begin
            sum  <= g_level[LEVELS-1].half_q ^ carry;
            cout <= kpg_last[WIDTH][1];
        end
    end

endmodule

// File: exponent_path.sv
`timescale 1ns/1ps

module exponent_path #(
    parameter int ALIGN_DELAY = 7
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  fpmul_pkg::fp_fields_t op_a,
    input  fpmul_pkg::fp_fields_t op_b,
    output fpmul_pkg::sign_exp_t  sign_exp
);
    import fpmul_pkg::*;

    localparam int ADD_LAT = $clog2(EXP_W) + 1;
    localparam logic [EXP_W-1:0] BIAS_INV = ~EXP_BIAS[EXP_W-1:0];

    logic [EXP_W-1:0]     exp_sum;
    logic [EXP_W-1:0]     exp_unbiased;
    logic [2*ADD_LAT-1:0] sign_pipe;
    sign_exp_t            align_q [ALIGN_DELAY];

    prefix_adder #(.WIDTH(EXP_W)) u_exp_add (
        .clk    (clk),
        .arst_n (arst_n),
        .x      (op_a.exp),
        .y      (op_b.exp),
        .cin    (1'b0),
        .sum    (exp_sum),
        .cout   ()
    );

    // ea + eb - bias, modulo 2^8, result assumed in range
    prefix_adder #(.WIDTH(EXP_W)) u_bias_sub (
        .clk    (clk),
        .arst_n (arst_n),
        .x      (exp_sum),
        .y      (BIAS_INV),
        .cin    (1'b1),
        .sum    (exp_unbiased),
        .cout   ()
    );

    // sign matched to both adders, then sign and exponent wait for the mantissa
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sign_pipe <= '0;
            for (int i = 0; i < ALIGN_DELAY; i++) begin
                align_q[i] <= '0;
            end
        end else begin
            sign_pipe  <= {sign_pipe[2*ADD_LAT-2:0], op_a.sign ^ op_b.sign};
            align_q[0] <= '{sign: sign_pipe[2*ADD_LAT-1], exp: exp_unbiased};
            for (int i = 1; i < ALIGN_DELAY; i++) begin
                align_q[i] <= align_q[i-1];
            end
        end
    end

    assign sign_exp = align_q[ALIGN_DELAY-1];

endmodule

// File: normalize_pack.sv
`timescale 1ns/1ps

module normalize_pack (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [fpmul_pkg::PROD_W-1:0] mant_prod,
    input  fpmul_pkg::sign_exp_t         sign_exp,
    output fpmul_pkg::fp32_t             product
);
    import fpmul_pkg::*;

    fp32_t result;

    // product of two mantissas lies in [1, 4), top bit picks the window
    // slots still flushing out of reset carry a zero mantissa and stay zero
    always_comb begin
        result = '0;
        if (mant_prod[PROD_W-1]) begin
            result.sign = sign_exp.sign;
            result.exp  = sign_exp.exp + 1'b1;
            result.frac = mant_prod[PROD_W-2 -: FRAC_W];
        end else if (mant_prod[PROD_W-2]) begin
            result.sign = sign_exp.sign;
            result.exp  = sign_exp.exp;
            result.frac = mant_prod[PROD_W-3 -: FRAC_W];
        end
    end

    // truncated, no rounding
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            product <= '0;
        end else begin
            product <= result;
        end
    end

endmodule

// File: fpmul_top.sv
`timescale 1ns/1ps

module fpmul_top (
    input  logic             clk,
    input  logic             arst_n,
    input  fpmul_pkg::fp32_t a,
    input  fpmul_pkg::fp32_t b,
    output fpmul_pkg::fp32_t product
);
    import fpmul_pkg::*;

    localparam int MANT_ADD_LAT = $clog2(PROD_W) + 1;
    localparam int EXP_ADD_LAT  = $clog2(EXP_W) + 1;
    // pp stage + tree + mantissa adder, minus the two exponent adders
    localparam int ALIGN_DELAY  = 1 + CSA_LEVELS + MANT_ADD_LAT - 2 * EXP_ADD_LAT;

    fp_fields_t                    op_a;
    fp_fields_t                    op_b;
    logic [MANT_W-1:0][PROD_W-1:0] pp_rows;
    logic [PROD_W-1:0]             sum_row;
    logic [PROD_W-1:0]             carry_row;
    logic [PROD_W-1:0]             mant_prod;
    sign_exp_t                     sign_exp;

    // operand capture with the hidden bit restored
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_a <= '0;
            op_b <= '0;
        end else begin
            op_a <= '{sign: a.sign, exp: a.exp, mant: {1'b1, a.frac}};
            op_b <= '{sign: b.sign, exp: b.exp, mant: {1'b1, b.frac}};
        end
    end

    partial_products u_pp (
        .clk    (clk),
        .arst_n (arst_n),
        .mant_a (op_a.mant),
        .mant_b (op_b.mant),
        .rows   (pp_rows)
    );

    csa_tree u_tree (
        .clk       (clk),
        .arst_n    (arst_n),
        .rows      (pp_rows),
        .sum_row   (sum_row),
        .carry_row (carry_row)
    );

    prefix_adder #(.WIDTH(PROD_W)) u_mant_add (
        .clk    (clk),
        .arst_n (arst_n),
        .x      (sum_row),
        .y      (carry_row),
        .cin    (1'b0),
        .sum    (mant_prod),
        .cout   ()
    );

    exponent_path #(.ALIGN_DELAY(ALIGN_DELAY)) u_exp (
        .clk      (clk),
        .arst_n   (arst_n),
        .op_a     (op_a),
        .op_b     (op_b),
        .sign_exp (sign_exp)
    );

    normalize_pack u_norm (
        .clk       (clk),
        .arst_n    (arst_n),
        .mant_prod (mant_prod),
        .sign_exp  (sign_exp),
        .product   (product)
    );

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // reset released on a rising edge, so the first flop update sees it still low
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

// File: tb_fpmul_ref.svh
`ifndef TB_FPMUL_REF_SVH
`define TB_FPMUL_REF_SVH

// expected product of two normal single precision words
// sign xor, full 48-bit mantissa product, truncated fraction
function automatic logic [31:0] ref_fp_mul(input logic [31:0] x, input logic [31:0] y);
    logic [23:0] mant_x;
    logic [23:0] mant_y;
    logic [47:0] mant_prod;
    logic        sign;
    int          exp_res;
    logic [22:0] frac;

    mant_x    = {1'b1, x[22:0]};
    mant_y    = {1'b1, y[22:0]};
    mant_prod = 48'(mant_x) * 48'(mant_y);
    sign      = x[31] ^ y[31];
    exp_res   = int'(x[30:23]) + int'(y[30:23]) - 127;

    // product in [2, 4) moves the binary point one place
    if (mant_prod[47]) begin
        exp_res = exp_res + 1;
        frac    = mant_prod[46:24];
    end else begin
        frac = mant_prod[45:23];
    end

    return {sign, exp_res[7:0], frac};
endfunction

`endif

// File: tb_fpmul.sv
`timescale 1ns/1ps

module tb_fpmul;
    import fpmul_pkg::*;

    localparam int RESET_CYCLES   = 2;
    localparam int LATENCY        = 17;
    localparam int DIRECTED_COUNT = 8;
    localparam int RANDOM_COUNT   = 300;
    localparam int NUM_VECTORS    = DIRECTED_COUNT + RANDOM_COUNT;
    localparam int TIMEOUT_CYCLES = NUM_VECTORS + 40;
    localparam int RAND_EXP_MIN   = 64;
    localparam int RAND_EXP_MAX   = 190;

    logic  clk;
    logic  arst_n;
    fp32_t a;
    fp32_t b;
    fp32_t product;

    logic [31:0] expected_q[$];
    int          seed        = 97;
    int          check_count = 0;
    int          error_count = 0;

    `include "tb_fpmul_ref.svh"

    tb_clock #(
        .HALF_PERIOD  (5),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    fpmul_top DUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .a       (a),
        .b       (b),
        .product (product)
    );

    task automatic compare_value(input logic [31:0] got, input logic [31:0] want,
                                 input string what);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("Fail at %0t: %s, got %h, expected %h", $time, what, got, want);
        end
    endtask

    // normal operand, exponent kept inside the random range
    function automatic fp32_t random_operand();
        fp32_t op;
        int    r;
        int    e;
        r       = $random(seed);
        op.sign = r[0];
        r       = $random(seed);
        e       = RAND_EXP_MIN + int'($unsigned(r) % (RAND_EXP_MAX - RAND_EXP_MIN + 1));
        op.exp  = e[7:0];
        r       = $random(seed);
        op.frac = r[22:0];
        return op;
    endfunction

    // drive one pair on this edge, then move to the next edge
    task automatic apply_pair(input fp32_t x, input fp32_t y);
        a <= x;
        b <= y;
        expected_q.push_back(ref_fp_mul(x, y));
        @(posedge clk);
    endtask

    task automatic apply_known(input logic [31:0] x, input logic [31:0] y,
                               input logic [31:0] want);
        compare_value(ref_fp_mul(x, y), want, "reference model vs known product");
        apply_pair(x, y);
    endtask

    initial begin : stimulus
        fp32_t ra;
        fp32_t rb;
        a <= '0;
        b <= '0;
        // first pair lands on the reset release edge
        repeat (RESET_CYCLES) @(posedge clk);
        // 1.0 x 1.0 and 1.25 x 1.5, no shift
        apply_known(32'h3F80_0000, 32'h3F80_0000, 32'h3F80_0000);
        apply_known(32'h3FA0_0000, 32'h3FC0_0000, 32'h3FF0_0000);
        // 1.5 x 1.5 and 1.75 x 1.75 take the top bit path
        apply_known(32'h3FC0_0000, 32'h3FC0_0000, 32'h4010_0000);
        apply_known(32'h3FE0_0000, 32'h3FE0_0000, 32'h4044_0000);
        // sign combinations of 1.25 x 1.5
        apply_known(32'h3FA0_0000, 32'hBFC0_0000, 32'hBFF0_0000);
        apply_known(32'hBFA0_0000, 32'h3FC0_0000, 32'hBFF0_0000);
        apply_known(32'hBFA0_0000, 32'hBFC0_0000, 32'h3FF0_0000);
        apply_known(32'h3FA0_0000, 32'h3FC0_0000, 32'h3FF0_0000);
        // back to back random stream
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            ra = random_operand();
            rb = random_operand();
            apply_pair(ra, rb);
        end
        a <= '0;
        b <= '0;
    end

    // product only moves on rising edges, so it is read on the falling edge
    initial begin : compare
        logic [31:0] want;
        repeat (RESET_CYCLES) @(posedge clk);
        // pipeline still holds reset values
        for (int i = 0; i < LATENCY; i++) begin
            @(negedge clk);
            compare_value(product, '0, "product not zero before first result");
        end
        for (int i = 0; i < NUM_VECTORS; i++) begin
            @(negedge clk);
            if (expected_q.size() == 0) begin
                error_count++;
                $display("Error at %0t: no expected value queued for product %0d", $time, i);
            end else begin
                want = expected_q.pop_front();
                compare_value(product, want, $sformatf("product %0d", i));
            end
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: fpmul.f
+incdir+.
fpmul_pkg.sv
partial_products.sv
csa_tree.sv
prefix_adder.sv
exponent_path.sv
normalize_pack.sv
fpmul_top.sv
tb_clock.sv
tb_fpmul.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary -Wno-fatal --top-module tb_fpmul -f fpmul.f \
    --Mdir "$BUILD_DIR" -o tb_fpmul

"$BUILD_DIR/tb_fpmul" | tee "$LOG"

if grep -q "ALL CHECKS PASSED" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG"
    exit 1
fi
